// File: list.f
src/tile_pkg.sv
src/tcdm_if.sv
src/tile_request_decode.sv
src/tile_bank_array.sv
src/tile_remote_port.sv
src/tile_response_collect.sv
src/tcdm_tile.sv
verification/tcdm_tile_properties.sv
verification/tcdm_tile_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the TCDM tile testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tcdm_tile_tb \
  -Mdir obj_dir \
  -f list.f

./obj_dir/Vtcdm_tile_tb

// File: src/tcdm_if.sv
////////////////////////////////////////////////////////////
// Per-core request/response bus between the decoders and
// the bank array or the remote port
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface tcdm_if #(
  parameter int unsigned NumCores = 2
) ();

  // Request, driven by the decoder
  logic               [NumCores-1:0] req_valid;
  tile_pkg::op_e      [NumCores-1:0] req_op;
  tile_pkg::addr_t    [NumCores-1:0] req_addr;
  tile_pkg::data_t    [NumCores-1:0] req_wdata;
  tile_pkg::strb_t    [NumCores-1:0] req_strb;
  logic               [NumCores-1:0] req_ready;

  // Response, no ready since the collector always accepts
  logic               [NumCores-1:0] resp_valid;
  tile_pkg::data_t    [NumCores-1:0] resp_rdata;

  modport req_mp (
    output req_valid, req_op, req_addr, req_wdata, req_strb,
    input  req_ready, resp_valid, resp_rdata
  );

  modport bank_mp (
    input  req_valid, req_op, req_addr, req_wdata, req_strb,
    output req_ready, resp_valid, resp_rdata
  );

endinterface : tcdm_if

// File: src/tcdm_tile.sv
////////////////////////////////////////////////////////////
// TCDM tile top level wiring decode, banks, remote port
// and response collection
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tcdm_tile #(
  parameter int unsigned     NumCores     = 2,
  parameter int unsigned     NumBanks     = 4,
  parameter tile_pkg::addr_t TcdmBaseAddr = '0,
  localparam int unsigned    CoreW        = (NumCores > 1) ? $clog2(NumCores) : 1
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  tile_pkg::tile_id_t             tile_id_i,
  // Core requests
  input  logic            [NumCores-1:0] core_req_valid_i,
  input  tile_pkg::op_e   [NumCores-1:0] core_req_op_i,
  input  tile_pkg::addr_t [NumCores-1:0] core_req_addr_i,
  input  tile_pkg::data_t [NumCores-1:0] core_req_wdata_i,
  input  tile_pkg::strb_t [NumCores-1:0] core_req_strb_i,
  output logic            [NumCores-1:0] core_req_ready_o,
  // Core responses
  output logic            [NumCores-1:0] core_resp_valid_o,
  output tile_pkg::data_t [NumCores-1:0] core_resp_rdata_o,
  output logic            [NumCores-1:0] core_resp_error_o,
  input  logic            [NumCores-1:0] core_resp_ready_i,
  // Remote port
  output logic                           remote_req_valid_o,
  output tile_pkg::op_e                  remote_req_op_o,
  output tile_pkg::addr_t                remote_req_addr_o,
  output tile_pkg::data_t                remote_req_wdata_o,
  output tile_pkg::strb_t                remote_req_strb_o,
  output logic            [CoreW-1:0]    remote_req_core_o,
  input  logic                           remote_req_ready_i,
  input  logic                           remote_resp_valid_i,
  input  tile_pkg::data_t                remote_resp_rdata_i,
  input  logic            [CoreW-1:0]    remote_resp_core_i,
  output logic                           remote_resp_ready_o
);

  logic [NumCores-1:0] err_valid;
  logic [NumCores-1:0] core_done;

  tcdm_if #(.NumCores(NumCores)) local_bus ();
  tcdm_if #(.NumCores(NumCores)) remote_bus ();

  tile_request_decode #(
    .NumCores    (NumCores    ),
    .NumBanks    (NumBanks    ),
    .TcdmBaseAddr(TcdmBaseAddr)
  ) i_decode (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .tile_id_i       (tile_id_i       ),
    .core_req_valid_i(core_req_valid_i),
    .core_req_op_i   (core_req_op_i   ),
    .core_req_addr_i (core_req_addr_i ),
    .core_req_wdata_i(core_req_wdata_i),
    .core_req_strb_i (core_req_strb_i ),
    .core_req_ready_o(core_req_ready_o),
    .core_done_i     (core_done       ),
    .local_o         (local_bus       ),
    .remote_o        (remote_bus      ),
    .err_valid_o     (err_valid       )
  );

  tile_bank_array #(
    .NumCores(NumCores),
    .NumBanks(NumBanks)
  ) i_banks (
    .clk_i  (clk_i    ),
    .rst_n_i(rst_n_i  ),
    .bus_i  (local_bus)
  );

  tile_remote_port #(
    .NumCores(NumCores)
  ) i_remote (
    .clk_i              (clk_i              ),
    .rst_n_i            (rst_n_i            ),
    .bus_i              (remote_bus         ),
    .remote_req_valid_o (remote_req_valid_o ),
    .remote_req_op_o    (remote_req_op_o    ),
    .remote_req_addr_o  (remote_req_addr_o  ),
    .remote_req_wdata_o (remote_req_wdata_o ),
    .remote_req_strb_o  (remote_req_strb_o  ),
    .remote_req_core_o  (remote_req_core_o  ),
    .remote_req_ready_i (remote_req_ready_i ),
    .remote_resp_valid_i(remote_resp_valid_i),
    .remote_resp_rdata_i(remote_resp_rdata_i),
    .remote_resp_core_i (remote_resp_core_i ),
    .remote_resp_ready_o(remote_resp_ready_o)
  );

  tile_response_collect #(
    .NumCores(NumCores)
  ) i_collect (
    .clk_i            (clk_i            ),
    .rst_n_i          (rst_n_i          ),
    .local_i          (local_bus        ),
    .remote_i         (remote_bus       ),
    .err_valid_i      (err_valid        ),
    .core_resp_valid_o(core_resp_valid_o),
    .core_resp_rdata_o(core_resp_rdata_o),
    .core_resp_error_o(core_resp_error_o),
    .core_resp_ready_i(core_resp_ready_i),
    .core_done_o      (core_done        )
  );

endmodule : tcdm_tile

// File: src/tile_bank_array.sv
////////////////////////////////////////////////////////////
// Word-interleaved SRAM banks with per-bank round-robin
// arbitration and read data routing back to the cores
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tile_bank_array #(
  parameter int unsigned NumCores = 2,
  parameter int unsigned NumBanks = 4
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  tcdm_if.bank_mp bus_i
);

  localparam int unsigned CoreW  = (NumCores > 1) ? $clog2(NumCores) : 1;
  localparam int unsigned BankW  = $clog2(NumBanks);
  localparam int unsigned RowLsb = tile_pkg::ByteOffset + BankW + tile_pkg::TileIdWidth;

  logic [NumCores-1:0][NumBanks-1:0] gnt_map;
  logic [NumCores-1:0][NumBanks-1:0] hit_map;
  tile_pkg::data_t [NumBanks-1:0]    bank_rdata;

  for (genvar b = 0; b < NumBanks; b++) begin : gen_banks
    logic [NumCores-1:0] req;
    logic                gnt_valid;
    logic [CoreW-1:0]    gnt_idx;
    logic [CoreW-1:0]    rr_q;
    logic [CoreW-1:0]    core_q;
    logic                active_q;
    logic                rd_q;
    tile_pkg::row_t      row;
    tile_pkg::data_t     rdata_q;
    tile_pkg::data_t     mem_q [tile_pkg::BankWords];

    for (genvar c = 0; c < NumCores; c++) begin : gen_core
      assign req[c] = bus_i.req_valid[c] &&
                      (bus_i.req_addr[c][tile_pkg::ByteOffset +: BankW] == BankW'(b));
      assign gnt_map[c][b] = gnt_valid && (gnt_idx == CoreW'(c));
      assign hit_map[c][b] = active_q && (core_q == CoreW'(c));
    end

    // Search starts at the pointer, first requester wins
    always_comb begin
      int unsigned idx;
      gnt_valid = 1'b0;
      gnt_idx   = '0;
      for (int unsigned i = 0; i < NumCores; i++) begin
        idx = (rr_q + i) % NumCores;
        if (!gnt_valid && req[idx]) begin
          gnt_valid = 1'b1;
          gnt_idx   = CoreW'(idx);
        end
      end
    end

    assign row           = bus_i.req_addr[gnt_idx][RowLsb +: tile_pkg::BankAddrWidth];
    assign bank_rdata[b] = rd_q ? rdata_q : '0;

    always_ff @(posedge clk_i) begin
      if (gnt_valid) begin
        rdata_q <= mem_q[row];
        if (bus_i.req_op[gnt_idx] == tile_pkg::OP_WRITE) begin
          for (int k = 0; k < tile_pkg::StrbWidth; k++) begin
            if (bus_i.req_strb[gnt_idx][k]) begin
              mem_q[row][8*k +: 8] <= bus_i.req_wdata[gnt_idx][8*k +: 8];
            end
          end
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        rr_q     <= '0;
        core_q   <= '0;
        active_q <= 1'b0;
        rd_q     <= 1'b0;
      end else begin
        active_q <= gnt_valid;
        if (gnt_valid) begin
          rr_q   <= (gnt_idx == CoreW'(NumCores - 1)) ? '0 : gnt_idx + 1'b1;
          core_q <= gnt_idx;
          rd_q   <= (bus_i.req_op[gnt_idx] == tile_pkg::OP_READ);
        end
      end
    end
  end

  // A core has at most one access in flight, so one bank hits at most
  always_comb begin
    for (int c = 0; c < NumCores; c++) begin
      bus_i.req_ready[c]  = |gnt_map[c];
      bus_i.resp_valid[c] = |hit_map[c];
      bus_i.resp_rdata[c] = '0;
      for (int b = 0; b < NumBanks; b++) begin
        if (hit_map[c][b]) begin
          bus_i.resp_rdata[c] = bank_rdata[b];
        end
      end
    end
  end

endmodule : tile_bank_array

// File: src/tile_pkg.sv
////////////////////////////////////////////////////////////
// Address map constants, widths, word types and the opcode
// and decode target enums of the TCDM tile
////////////////////////////////////////////////////////////

package tile_pkg;

  localparam int unsigned DataWidth     = 32;
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned StrbWidth     = DataWidth / 8;
  localparam int unsigned ByteOffset    = $clog2(StrbWidth);

  // Each tile holds 4 word-interleaved banks
  localparam int unsigned BankWords     = 64;
  localparam int unsigned BankAddrWidth = $clog2(BankWords);

  localparam int unsigned NumTiles      = 4;
  localparam int unsigned TileIdWidth   = $clog2(NumTiles);

  // Whole TCDM region shared by all tiles, in bytes
  localparam int unsigned TcdmSize      = NumTiles * 4 * BankWords * StrbWidth;

  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [AddrWidth-1:0]     addr_t;
  typedef logic [StrbWidth-1:0]     strb_t;
  typedef logic [BankAddrWidth-1:0] row_t;
  typedef logic [TileIdWidth-1:0]   tile_id_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  typedef enum logic [1:0] {
    TGT_LOCAL  = 2'd0,
    TGT_REMOTE = 2'd1,
    TGT_ERROR  = 2'd2
  } target_e;

endpackage : tile_pkg

// File: src/tile_remote_port.sv
////////////////////////////////////////////////////////////
// Remote request arbitration with output register and
// delivery of remote responses by core id
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tile_remote_port #(
  parameter int unsigned NumCores = 2,
  localparam int unsigned CoreW   = (NumCores > 1) ? $clog2(NumCores) : 1
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  tcdm_if.bank_mp            bus_i,
  output logic               remote_req_valid_o,
  output tile_pkg::op_e      remote_req_op_o,
  output tile_pkg::addr_t    remote_req_addr_o,
  output tile_pkg::data_t    remote_req_wdata_o,
  output tile_pkg::strb_t    remote_req_strb_o,
  output logic [CoreW-1:0]   remote_req_core_o,
  input  logic               remote_req_ready_i,
  input  logic               remote_resp_valid_i,
  input  tile_pkg::data_t    remote_resp_rdata_i,
  input  logic [CoreW-1:0]   remote_resp_core_i,
  output logic               remote_resp_ready_o
);

  logic             gnt_valid;
  logic [CoreW-1:0] gnt_idx;
  logic [CoreW-1:0] rr_q;
  logic             load;

  // Register is free when empty or draining this cycle
  assign load = !remote_req_valid_o || remote_req_ready_i;

  always_comb begin
    int unsigned idx;
    gnt_valid = 1'b0;
    gnt_idx   = '0;
    for (int unsigned i = 0; i < NumCores; i++) begin
      idx = (rr_q + i) % NumCores;
      if (!gnt_valid && bus_i.req_valid[idx]) begin
        gnt_valid = 1'b1;
        gnt_idx   = CoreW'(idx);
      end
    end
  end

  always_comb begin
    for (int c = 0; c < NumCores; c++) begin
      bus_i.req_ready[c]  = load && gnt_valid && (gnt_idx == CoreW'(c));
      bus_i.resp_valid[c] = remote_resp_valid_i && (remote_resp_core_i == CoreW'(c));
      bus_i.resp_rdata[c] = remote_resp_rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      remote_req_valid_o <= 1'b0;
      remote_req_core_o  <= '0;
      rr_q               <= '0;
    end else if (load) begin
      remote_req_valid_o <= gnt_valid;
      if (gnt_valid) begin
        remote_req_core_o <= gnt_idx;
        rr_q              <= (gnt_idx == CoreW'(NumCores - 1)) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load && gnt_valid) begin
      remote_req_op_o    <= bus_i.req_op[gnt_idx];
      remote_req_addr_o  <= bus_i.req_addr[gnt_idx];
      remote_req_wdata_o <= bus_i.req_wdata[gnt_idx];
      remote_req_strb_o  <= bus_i.req_strb[gnt_idx];
    end
  end

  assign remote_resp_ready_o = 1'b1;

endmodule : tile_remote_port

// File: src/tile_request_decode.sv
////////////////////////////////////////////////////////////
// Per-core address decode and steering to the local bus,
// the remote bus or an error response
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tile_request_decode #(
  parameter int unsigned     NumCores     = 2,
  parameter int unsigned     NumBanks     = 4,
  parameter tile_pkg::addr_t TcdmBaseAddr = '0
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  tile_pkg::tile_id_t                tile_id_i,
  input  logic            [NumCores-1:0]    core_req_valid_i,
  input  tile_pkg::op_e   [NumCores-1:0]    core_req_op_i,
  input  tile_pkg::addr_t [NumCores-1:0]    core_req_addr_i,
  input  tile_pkg::data_t [NumCores-1:0]    core_req_wdata_i,
  input  tile_pkg::strb_t [NumCores-1:0]    core_req_strb_i,
  output logic            [NumCores-1:0]    core_req_ready_o,
  input  logic            [NumCores-1:0]    core_done_i,
  tcdm_if.req_mp                            local_o,
  tcdm_if.req_mp                            remote_o,
  output logic            [NumCores-1:0]    err_valid_o
);

  localparam int unsigned TileLsb = tile_pkg::ByteOffset + $clog2(NumBanks);

  tile_pkg::addr_t   [NumCores-1:0] offset;
  tile_pkg::target_e [NumCores-1:0] target;
  logic              [NumCores-1:0] busy_q;

  // Payload goes to both buses, only the valid is steered
  assign local_o.req_op     = core_req_op_i;
  assign local_o.req_wdata  = core_req_wdata_i;
  assign local_o.req_strb   = core_req_strb_i;
  assign remote_o.req_op    = core_req_op_i;
  assign remote_o.req_addr  = core_req_addr_i;
  assign remote_o.req_wdata = core_req_wdata_i;
  assign remote_o.req_strb  = core_req_strb_i;

  // Banks see the offset into the TCDM region
  assign local_o.req_addr   = offset;

  always_comb begin
    for (int c = 0; c < NumCores; c++) begin
      offset[c] = core_req_addr_i[c] - TcdmBaseAddr;
      if (offset[c] >= tile_pkg::TcdmSize) begin
        target[c] = tile_pkg::TGT_ERROR;
      end else if (offset[c][TileLsb +: tile_pkg::TileIdWidth] == tile_id_i) begin
        target[c] = tile_pkg::TGT_LOCAL;
      end else begin
        target[c] = tile_pkg::TGT_REMOTE;
      end

      local_o.req_valid[c]  = core_req_valid_i[c] && !busy_q[c] &&
                              (target[c] == tile_pkg::TGT_LOCAL);
      remote_o.req_valid[c] = core_req_valid_i[c] && !busy_q[c] &&
                              (target[c] == tile_pkg::TGT_REMOTE);
      err_valid_o[c]        = core_req_valid_i[c] && !busy_q[c] &&
                              (target[c] == tile_pkg::TGT_ERROR);

      case (target[c])
        tile_pkg::TGT_LOCAL:  core_req_ready_o[c] = !busy_q[c] && local_o.req_ready[c];
        tile_pkg::TGT_REMOTE: core_req_ready_o[c] = !busy_q[c] && remote_o.req_ready[c];
        default:              core_req_ready_o[c] = !busy_q[c];
      endcase
    end
  end

  // One outstanding request per core until its response is taken
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= '0;
    end else begin
      busy_q <= (busy_q & ~core_done_i) | (core_req_valid_i & core_req_ready_o);
    end
  end

endmodule : tile_request_decode

// File: src/tile_response_collect.sv
////////////////////////////////////////////////////////////
// Per-core response registers merging local, remote and
// error results under core back-pressure
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tile_response_collect #(
  parameter int unsigned NumCores = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  tcdm_if.req_mp                         local_i,
  tcdm_if.req_mp                         remote_i,
  input  logic            [NumCores-1:0] err_valid_i,
  output logic            [NumCores-1:0] core_resp_valid_o,
  output tile_pkg::data_t [NumCores-1:0] core_resp_rdata_o,
  output logic            [NumCores-1:0] core_resp_error_o,
  input  logic            [NumCores-1:0] core_resp_ready_i,
  output logic            [NumCores-1:0] core_done_o
);

  logic [NumCores-1:0] load;

  // Only one source answers a given core at a time
  assign load        = local_i.resp_valid | remote_i.resp_valid | err_valid_i;
  assign core_done_o = core_resp_valid_o & core_resp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      core_resp_valid_o <= '0;
      core_resp_error_o <= '0;
    end else begin
      for (int c = 0; c < NumCores; c++) begin
        if (load[c]) begin
          core_resp_valid_o[c] <= 1'b1;
          core_resp_error_o[c] <= err_valid_i[c];
        end else if (core_resp_ready_i[c]) begin
          core_resp_valid_o[c] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int c = 0; c < NumCores; c++) begin
      if (load[c]) begin
        if (local_i.resp_valid[c]) begin
          core_resp_rdata_o[c] <= local_i.resp_rdata[c];
        end else if (remote_i.resp_valid[c]) begin
          core_resp_rdata_o[c] <= remote_i.resp_rdata[c];
        end else begin
          core_resp_rdata_o[c] <= '0;
        end
      end
    end
  end

endmodule : tile_response_collect

// File: verification/tcdm_tile_properties.sv
////////////////////////////////////////////////////////////
// Handshake stability and reset assertions for the tile
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tcdm_tile_properties #(
  parameter int unsigned NumCores = 2
) (
  input logic                           clk_i,
  input logic                           rst_n_i,
  input logic            [NumCores-1:0] core_req_valid_i,
  input logic            [NumCores-1:0] core_req_ready_o,
  input tile_pkg::addr_t [NumCores-1:0] core_req_addr_i,
  input tile_pkg::data_t [NumCores-1:0] core_req_wdata_i,
  input logic            [NumCores-1:0] core_resp_valid_o,
  input logic            [NumCores-1:0] core_resp_ready_i,
  input logic            [NumCores-1:0] core_resp_error_o,
  input tile_pkg::data_t [NumCores-1:0] core_resp_rdata_o,
  input logic                           remote_req_valid_o,
  input logic                           remote_req_ready_i,
  input tile_pkg::op_e                  remote_req_op_o,
  input tile_pkg::addr_t                remote_req_addr_o,
  input tile_pkg::data_t                remote_req_wdata_o,
  input tile_pkg::strb_t                remote_req_strb_o
);

  for (genvar c = 0; c < NumCores; c++) begin : gen_core
    req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      core_req_valid_i[c] && !core_req_ready_o[c] |=> core_req_valid_i[c] &&
      $stable(core_req_addr_i[c]) && $stable(core_req_wdata_i[c]))
      else $error("core request changed while stalled");
    resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      core_resp_valid_o[c] && !core_resp_ready_i[c] |=> core_resp_valid_o[c] &&
      $stable(core_resp_rdata_o[c]) && $stable(core_resp_error_o[c]))
      else $error("core response changed while stalled");
  end

  remote_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    remote_req_valid_o && !remote_req_ready_i |=> remote_req_valid_o &&
    $stable(remote_req_op_o) && $stable(remote_req_addr_o) &&
    $stable(remote_req_wdata_o) && $stable(remote_req_strb_o))
    else $error("remote request changed while stalled");

  // Sampled mid-cycle while reset is held
  reset_quiet: assert property (@(negedge clk_i)
    !rst_n_i |-> !(|core_resp_valid_o) && !remote_req_valid_o)
    else $error("valid output high during reset");

endmodule : tcdm_tile_properties

bind tcdm_tile tcdm_tile_properties #(.NumCores(NumCores)) tcdm_tile_properties_i (.*);

// File: verification/tcdm_tile_tb.sv
////////////////////////////////////////////////////////////
// Table-driven testbench for the TCDM tile with a remote
// memory responder, compare task and watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tcdm_tile_tb;

  localparam int unsigned NumCores = 2;
  localparam int unsigned CoreW    = 1;

  typedef struct {
    int              core;
    tile_pkg::op_e   op;
    tile_pkg::addr_t addr;
    tile_pkg::data_t wdata;
    tile_pkg::strb_t strb;
    tile_pkg::data_t exp_rdata;
    int              exp_err;
    int              remote;
    int              pair;
    int              hold;
  } access_t;

  logic                           clk_i;
  logic                           rst_n_i;
  tile_pkg::tile_id_t             tile_id_i;
  logic            [NumCores-1:0] core_req_valid_i;
  tile_pkg::op_e   [NumCores-1:0] core_req_op_i;
  tile_pkg::addr_t [NumCores-1:0] core_req_addr_i;
  tile_pkg::data_t [NumCores-1:0] core_req_wdata_i;
  tile_pkg::strb_t [NumCores-1:0] core_req_strb_i;
  logic            [NumCores-1:0] core_req_ready_o;
  logic            [NumCores-1:0] core_resp_valid_o;
  tile_pkg::data_t [NumCores-1:0] core_resp_rdata_o;
  logic            [NumCores-1:0] core_resp_error_o;
  logic            [NumCores-1:0] core_resp_ready_i;
  logic                           remote_req_valid_o;
  tile_pkg::op_e                  remote_req_op_o;
  tile_pkg::addr_t                remote_req_addr_o;
  tile_pkg::data_t                remote_req_wdata_o;
  tile_pkg::strb_t                remote_req_strb_o;
  logic            [CoreW-1:0]    remote_req_core_o;
  logic                           remote_req_ready_i;
  logic                           remote_resp_valid_i;
  tile_pkg::data_t                remote_resp_rdata_i;
  logic            [CoreW-1:0]    remote_resp_core_i;
  logic                           remote_resp_ready_o;

  access_t         tbl[$];
  // Last request accepted by the remote responder
  int              rem_count;
  tile_pkg::op_e   rem_op;
  tile_pkg::addr_t rem_addr;
  tile_pkg::data_t rem_wdata;
  tile_pkg::strb_t rem_strb;
  logic [CoreW-1:0] rem_core;

  tcdm_tile #(
    .NumCores    (NumCores),
    .NumBanks    (4       ),
    .TcdmBaseAddr('0      )
  ) tcdm_tile_i (.*);

  always #50 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Test failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic tile_pkg::data_t merge_bytes(input tile_pkg::data_t old_word,
                                                  input tile_pkg::data_t new_word,
                                                  input tile_pkg::strb_t strb);
    tile_pkg::data_t word;
    word = old_word;
    for (int k = 0; k < 4; k++) begin
      if (strb[k]) begin
        word[8*k +: 8] = new_word[8*k +: 8];
      end
    end
    return word;
  endfunction

  task automatic add_row(input int core, input tile_pkg::op_e op, input tile_pkg::addr_t addr,
                         input tile_pkg::data_t wdata, input tile_pkg::strb_t strb,
                         input tile_pkg::data_t exp_rdata, input int exp_err,
                         input int remote, input int pair, input int hold);
    access_t a;
    a.core      = core;
    a.op        = op;
    a.addr      = addr;
    a.wdata     = wdata;
    a.strb      = strb;
    a.exp_rdata = exp_rdata;
    a.exp_err   = exp_err;
    a.remote    = remote;
    a.pair      = pair;
    a.hold      = hold;
    tbl.push_back(a);
  endtask

  // Issues one access and follows it to the response handshake
  task automatic run_row(input int r);
    access_t         row;
    int              c;
    int              lat;
    int              seen;
    tile_pkg::data_t rdata;
    row  = tbl[r];
    c    = row.core;
    seen = rem_count;
    core_req_valid_i[c]  = 1'b1;
    core_req_op_i[c]     = row.op;
    core_req_addr_i[c]   = row.addr;
    core_req_wdata_i[c]  = row.wdata;
    core_req_strb_i[c]   = row.strb;
    core_resp_ready_i[c] = (row.hold == 0);
    @(negedge clk_i);
    while (!core_req_ready_o[c]) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #10;
    core_req_valid_i[c] = 1'b0;
    lat = 0;
    do begin
      @(negedge clk_i);
      lat++;
    end while (!core_resp_valid_o[c]);
    if (row.remote == 0) begin
      check_value("core_resp_valid_o latency", 32'(lat), (row.exp_err != 0) ? 32'd1 : 32'd2);
    end
    check_value("core_resp_rdata_o", core_resp_rdata_o[c], row.exp_rdata);
    check_value("core_resp_error_o", 32'(core_resp_error_o[c]), 32'(row.exp_err));
    rdata = core_resp_rdata_o[c];
    // Stalled response stays put and the core stays blocked
    for (int h = 0; h < row.hold; h++) begin
      @(negedge clk_i);
      check_value("core_resp_valid_o", 32'(core_resp_valid_o[c]), 32'd1);
      check_value("core_resp_rdata_o", core_resp_rdata_o[c], rdata);
      check_value("core_req_ready_o", 32'(core_req_ready_o[c]), 32'd0);
    end
    if (row.hold != 0) begin
      @(posedge clk_i);
      #10;
      core_resp_ready_i[c] = 1'b1;
    end
    @(posedge clk_i);
    #10;
    check_value("remote_req_valid_o transfers", 32'(rem_count - seen), 32'(row.remote));
    if (row.remote != 0) begin
      check_value("remote_req_addr_o", rem_addr, row.addr);
      check_value("remote_req_op_o", 32'(rem_op), 32'(row.op));
      check_value("remote_req_wdata_o", rem_wdata, row.wdata);
      check_value("remote_req_strb_o", 32'(rem_strb), 32'(row.strb));
      check_value("remote_req_core_o", 32'(rem_core), 32'(c));
    end
  endtask

  initial begin : remote_responder
    void'($urandom(32'he8c9a0e2));
    remote_req_ready_i  = 1'b0;
    remote_resp_valid_i = 1'b0;
    remote_resp_rdata_i = '0;
    remote_resp_core_i  = '0;
    rem_count           = 0;
    forever begin
      @(posedge clk_i);
      #10;
      if (remote_req_valid_o) begin
        repeat ($urandom_range(3, 0)) begin
          @(posedge clk_i);
          #10;
        end
        remote_req_ready_i = 1'b1;
        rem_op    = remote_req_op_o;
        rem_addr  = remote_req_addr_o;
        rem_wdata = remote_req_wdata_o;
        rem_strb  = remote_req_strb_o;
        rem_core  = remote_req_core_o;
        rem_count++;
        @(posedge clk_i);
        #10;
        remote_req_ready_i = 1'b0;
        repeat ($urandom_range(3, 0)) begin
          @(posedge clk_i);
          #10;
        end
        remote_resp_valid_i = 1'b1;
        remote_resp_rdata_i = rem_addr ^ 32'h5a5a_5a5a;
        remote_resp_core_i  = rem_core;
        @(negedge clk_i);
        check_value("remote_resp_ready_o", 32'(remote_resp_ready_o), 32'd1);
        @(posedge clk_i);
        #10;
        remote_resp_valid_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #1;
    repeat (tbl.size() * 40 + 10) @(posedge clk_i);
    $display("Test failed");
    $fatal(1, "Timeout, the accesses did not complete in time");
  end

  initial begin
    int r;
    clk_i             = 1'b0;
    rst_n_i           = 1'b0;
    tile_id_i         = 2'd1;
    core_req_valid_i  = '0;
    core_req_addr_i   = '0;
    core_req_wdata_i  = '0;
    core_req_strb_i   = '0;
    core_resp_ready_i = '1;
    for (int c = 0; c < NumCores; c++) begin
      core_req_op_i[c] = tile_pkg::OP_READ;
    end

    // core, op, addr, wdata, strb, exp rdata, exp error, remote, paired with next, hold
    add_row(0, tile_pkg::OP_WRITE, 32'h0000_0010, 32'h1234_5678, 4'hf, '0, 0, 0, 0, 0);
    add_row(0, tile_pkg::OP_READ, 32'h0000_0010, '0, '0, 32'h1234_5678, 0, 0, 0, 0);
    add_row(1, tile_pkg::OP_WRITE, 32'h0000_0010, 32'haabb_ccdd, 4'h5, '0, 0, 0, 0, 0);
    add_row(1, tile_pkg::OP_READ, 32'h0000_0010, '0, '0,
            merge_bytes(32'h1234_5678, 32'haabb_ccdd, 4'h5), 0, 0, 0, 0);
    // One word per bank
    for (int b = 0; b < 4; b++) begin
      add_row(b % 2, tile_pkg::OP_WRITE, 32'h50 + 4 * b, 32'h600d_0050 + 4 * b, 4'hf,
              '0, 0, 0, 0, 0);
    end
    for (int b = 0; b < 4; b++) begin
      add_row(0, tile_pkg::OP_READ, 32'h50 + 4 * b, '0, '0, 32'h600d_0050 + 4 * b, 0, 0, 0, 0);
    end
    // Both cores on bank 0 in the same cycle
    add_row(0, tile_pkg::OP_WRITE, 32'h0000_0090, 32'hc0de_0090, 4'hf, '0, 0, 0, 1, 0);
    add_row(1, tile_pkg::OP_WRITE, 32'h0000_00d0, 32'hc0de_00d0, 4'hf, '0, 0, 0, 0, 0);
    add_row(0, tile_pkg::OP_READ, 32'h0000_0090, '0, '0, 32'hc0de_0090, 0, 0, 1, 0);
    add_row(1, tile_pkg::OP_READ, 32'h0000_00d0, '0, '0, 32'hc0de_00d0, 0, 0, 0, 0);
    add_row(1, tile_pkg::OP_WRITE, 32'h0000_0020, 32'hcafe_f00d, 4'h3,
            32'h0000_0020 ^ 32'h5a5a_5a5a, 0, 1, 0, 0);
    add_row(0, tile_pkg::OP_READ, 32'h0000_00c8, '0, '0,
            32'h0000_00c8 ^ 32'h5a5a_5a5a, 0, 1, 0, 0);
    add_row(0, tile_pkg::OP_READ, 32'h0000_1000, '0, '0, '0, 1, 0, 0, 4);
    add_row(1, tile_pkg::OP_WRITE, 32'h8000_0004, 32'hdead_beef, 4'hf, '0, 1, 0, 0, 0);
    add_row(0, tile_pkg::OP_READ, 32'h0000_0050, '0, '0, 32'h600d_0050, 0, 0, 0, 0);

    repeat (5) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;

    r = 0;
    while (r < tbl.size()) begin
      if (tbl[r].pair != 0) begin
        fork
          run_row(r);
          run_row(r + 1);
        join
        r += 2;
      end else begin
        run_row(r);
        r++;
      end
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule : tcdm_tile_tb
